// ==== files.f ====
+incdir+include
design/icache_pkg.sv
design/icache_ctrl_if.sv
design/icache_ctrl_fsm.sv
design/icache_counters.sv
design/icache_ways.sv
design/icache_axi_rd.sv
design/icache_top.sv
test/icache_axi_mem.sv
test/icache_tb.sv

// ==== test/icache_tb.sv ====
// Testbench for the two-way instruction cache with fetch checks against a reference model
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_tb;

   localparam int CLK_PERIOD = 10;
   localparam int WIN_W      = 8 << `ICACHE_P_WIN_BYTES;
   localparam int WIN_BYTES  = 1 << `ICACHE_P_WIN_BYTES;
   localparam int WINS       = 1 << (`ICACHE_P_LINE - `ICACHE_P_WIN_BYTES);
   localparam int RAND_N     = 300;
   localparam int FETCHES    = 3 + 6 + 12 + 6 + RAND_N + 2; // Pushes over all tests

   // Line L sits in set 2 and lines X, Y and Z share set 5
   localparam logic [`ICACHE_AW-1:0] LINE_L = 32'h0000_1040;
   localparam logic [`ICACHE_AW-1:0] SET_X  = 32'h0000_20A0;
   localparam logic [`ICACHE_AW-1:0] SET_Y  = 32'h0000_40A0;
   localparam logic [`ICACHE_AW-1:0] SET_Z  = 32'h0000_60A0;

   logic                  clk;
   logic                  rst;
   logic                  ce;
   logic [`ICACHE_AW-1:0] fetch_addr;
   logic                  stall;
   logic                  valid;
   logic [WIN_W-1:0]      insn;
   logic                  inv_we;
   logic [`ICACHE_AW-1:0] inv_addr;
   logic                  arvalid;
   logic                  arready;
   logic [`ICACHE_AW-1:0] araddr;
   logic [7:0]            arlen;
   logic [2:0]            arsize;
   logic                  rvalid;
   logic                  rready;
   logic [WIN_W-1:0]      rdata;
   logic                  rlast;
   logic                  mem_gaps;

   integer                seed;
   integer                data_errors;
   integer                other_errors;
   integer                compared;
   integer                ar_count;
   logic [`ICACHE_AW-1:0] last_araddr;
   logic                  booted;
   string                 test_name;
   logic [`ICACHE_AW-1:0] exp_addr [$];  // Fetches in flight with the oldest first
   string                 exp_name [$];

   initial
      begin
         clk = 1'b0;
         forever #(CLK_PERIOD / 2) clk = ~clk;
      end

   icache_top DUT (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_ce       (ce),
      .i_addr     (fetch_addr),
      .o_stall    (stall),
      .o_valid    (valid),
      .o_insn     (insn),
      .i_inv_we   (inv_we),
      .i_inv_addr (inv_addr),
      .o_arvalid  (arvalid),
      .i_arready  (arready),
      .o_araddr   (araddr),
      .o_arlen    (arlen),
      .o_arsize   (arsize),
      .i_rvalid   (rvalid),
      .o_rready   (rready),
      .i_rdata    (rdata),
      .i_rlast    (rlast)
   );

   icache_axi_mem u_mem (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_gaps    (mem_gaps),
      .i_arvalid (arvalid),
      .o_arready (arready),
      .i_araddr  (araddr),
      .i_arlen   (arlen),
      .i_arsize  (arsize),
      .o_rvalid  (rvalid),
      .i_rready  (rready),
      .o_rdata   (rdata),
      .o_rlast   (rlast)
   );

   // Upper half holds the window address and the lower half its inverse
   function automatic logic [WIN_W-1:0] ref_window(input logic [`ICACHE_AW-1:0] a);
      logic [`ICACHE_AW-1:0] w;
      w = a & ~(`ICACHE_AW'(WIN_BYTES - 1));
      return {w, ~w};
   endfunction

   task automatic fetch(input logic [`ICACHE_AW-1:0] a);
      while (stall)
         @(negedge clk);
      ce         = 1'b1;
      fetch_addr = a;
      @(negedge clk);
      ce = 1'b0;
   endtask

   // Invalidate rides on a fetch push
   task automatic invalidate_set(input logic [`ICACHE_AW-1:0] set_addr,
                                 input logic [`ICACHE_AW-1:0] a);
      while (stall)
         @(negedge clk);
      ce         = 1'b1;
      fetch_addr = a;
      inv_we     = 1'b1;
      inv_addr   = set_addr;
      @(negedge clk);
      ce     = 1'b0;
      inv_we = 1'b0;
   endtask

   task automatic wait_idle;
      while (stall)
         @(negedge clk);
   endtask

   task automatic check_ar_delta(input int snap, input int expected);
      int actual;
      wait_idle();
      actual = ar_count - snap;
      if (actual != expected)
         begin
            other_errors++;
            $display("ERROR %s: AR count expected %0d actual %0d", test_name, expected, actual);
         end
   endtask

   task automatic print_counts;
      $display("Compared %0d windows, %0d AR bursts, %0d data errors, %0d other errors",
               compared, ar_count, data_errors, other_errors);
   endtask

   // Output of the older item is taken on each advancing edge
   always @(posedge clk)
      begin : compare_proc
         logic [`ICACHE_AW-1:0] a;
         string                 n;
         logic [WIN_W-1:0]      exp;
         if (!rst && ce)
            begin
               if (valid)
                  begin
                     if (exp_addr.size() == 0)
                        begin
                           other_errors++;
                           $display("Output marked valid with no fetch in flight");
                        end
                     else
                        begin
                           a   = exp_addr.pop_front();
                           n   = exp_name.pop_front();
                           exp = ref_window(a);
                           compared++;
                           if (insn !== exp)
                              begin
                                 data_errors++;
                                 $display("ERROR %s: addr %h expected %h actual %h",
                                          n, a, exp, insn);
                              end
                        end
                  end
               exp_addr.push_back(fetch_addr);
               exp_name.push_back(test_name);
            end
      end

   // AR burst monitor, the missed fetch is the oldest one in flight
   always @(posedge clk)
      begin : ar_monitor
         logic [`ICACHE_AW-1:0] exp_line;
         if (!rst && !booted && arvalid)
            begin
               other_errors++;
               $display("AR request raised before the boot clear finished");
            end
         if (!rst && arvalid && arready)
            begin
               ar_count++;
               last_araddr = araddr;
               if (exp_addr.size() == 0)
                  begin
                     other_errors++;
                     $display("AR request issued with no fetch in flight");
                  end
               else
                  begin
                     exp_line = exp_addr[0] & ~(`ICACHE_AW'((1 << `ICACHE_P_LINE) - 1));
                     if (araddr !== exp_line)
                        begin
                           other_errors++;
                           $display("ERROR %s: araddr expected %h actual %h", test_name,
                                    exp_line, araddr);
                        end
                  end
               if (arlen != WINS - 1 || arsize != `ICACHE_P_WIN_BYTES)
                  begin
                     other_errors++;
                     $display("ERROR %s: arlen/arsize expected %0d/%0d actual %0d/%0d",
                              test_name, WINS - 1, `ICACHE_P_WIN_BYTES, arlen, arsize);
                  end
            end
      end

   initial
      begin
         #(CLK_PERIOD * (200 * FETCHES + 100));
         $display("Timeout: the run did not finish in the time allowed for %0d fetches", FETCHES);
         print_counts();
         $display("Test FAILED");
         $finish;
      end

   initial
      begin : stimulus
         int snap;
         int boot_cycles;
         seed         = 51018;
         rst          = 1'b1;
         ce           = 1'b0;
         fetch_addr   = '0;
         inv_we       = 1'b0;
         inv_addr     = '0;
         mem_gaps     = 1'b0;
         booted       = 1'b0;
         data_errors  = 0;
         other_errors = 0;
         compared     = 0;
         ar_count     = 0;
         last_araddr  = '0;
         test_name    = "reset";
         repeat (8)
            @(negedge clk);
         if (stall !== 1'b1 || valid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0)
            begin
               other_errors++;
               $display("Outputs not in their reset state while reset is held");
            end
         rst = 1'b0;

         test_name   = "boot";
         boot_cycles = 0;
         while (stall)
            begin
               boot_cycles++;
               @(negedge clk);
            end
         booted = 1'b1;
         if (boot_cycles != 16)
            begin
               other_errors++;
               $display("ERROR %s: stall cycles expected 16 actual %0d", test_name, boot_cycles);
            end

         test_name = "cold_miss";
         snap      = ar_count;
         fetch(LINE_L + 8);
         fetch(LINE_L + 16);
         fetch(LINE_L + 24);
         check_ar_delta(snap, 1);
         if (last_araddr !== LINE_L)
            begin
               other_errors++;
               $display("ERROR %s: araddr expected %h actual %h", test_name, LINE_L, last_araddr);
            end

         test_name = "line_hits";
         snap      = ar_count;
         for (int w = 0; w < WINS; w++)
            fetch(LINE_L + w * WIN_BYTES);
         fetch(LINE_L + 4);
         fetch(LINE_L + 12);
         check_ar_delta(snap, 0);

         // Victim pointer alternates, so Z lands in the way of X
         test_name = "set_conflict";
         snap      = ar_count;
         fetch(SET_X);
         fetch(SET_X + 8);
         fetch(SET_Y);
         fetch(SET_Y + 8);
         fetch(SET_Z);
         fetch(SET_Z + 8);
         check_ar_delta(snap, 3);
         snap = ar_count;
         fetch(SET_X);
         fetch(SET_X + 16);
         fetch(SET_Z + 16);
         check_ar_delta(snap, 1);
         if (last_araddr !== SET_X)
            begin
               other_errors++;
               $display("ERROR %s: araddr expected %h actual %h", test_name, SET_X, last_araddr);
            end
         snap = ar_count;
         fetch(SET_Z);
         fetch(SET_Z + 24);
         fetch(SET_Z + 8);
         check_ar_delta(snap, 0);

         test_name = "invalidate";
         snap      = ar_count;
         fetch(LINE_L);
         fetch(LINE_L + 8);
         check_ar_delta(snap, 0); // Still resident
         invalidate_set(LINE_L, SET_Z + 16);
         snap = ar_count;
         fetch(LINE_L + 8);
         fetch(LINE_L + 16);
         fetch(LINE_L + 24);
         check_ar_delta(snap, 1);

         test_name = "random";
         mem_gaps  = 1'b1;
         for (int i = 0; i < RAND_N; i++)
            begin
               if (($random(seed) & 7) == 0)
                  repeat (1 + ($random(seed) & 3))
                     @(negedge clk);
               fetch($random(seed) & 32'h0000_3FFF);
            end

         // Push the last random items out of the pipeline
         test_name = "drain";
         fetch(LINE_L);
         fetch(LINE_L + 8);
         wait_idle();
         if (exp_addr.size() != 2)
            begin
               other_errors++;
               $display("%0d fetches were never returned by the cache", exp_addr.size() - 2);
            end
         repeat (2)
            @(negedge clk);

         print_counts();
         if (data_errors == 0 && other_errors == 0)
            $display("Test OK");
         else
            $display("Test FAILED");
         $finish;
      end

endmodule

// ==== test/icache_axi_mem.sv ====
// AXI read slave model with optional random ready and valid gaps
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_axi_mem #(
   parameter int SEED = 51018
) (
   input  logic                                  i_clk,
   input  logic                                  i_rst,
   input  logic                                  i_gaps,     // Random stalls on AR and R
   input  logic                                  i_arvalid,
   output logic                                  o_arready,
   input  logic [`ICACHE_AW-1:0]                 i_araddr,
   input  logic [7:0]                            i_arlen,
   input  logic [2:0]                            i_arsize,
   output logic                                  o_rvalid,
   input  logic                                  i_rready,
   output logic [(8 << `ICACHE_P_WIN_BYTES)-1:0] o_rdata,
   output logic                                  o_rlast
);

   integer                seed;
   logic                  ar_hs;
   logic                  r_hs;
   logic [`ICACHE_AW-1:0] ar_addr_s;
   logic [7:0]            ar_len_s;
   logic [2:0]            ar_size_s;
   logic                  busy;       // Burst in progress
   logic [`ICACHE_AW-1:0] beat_addr;
   logic [7:0]            beats_left;

   initial
      begin
         seed       = SEED;
         busy       = 1'b0;
         beat_addr  = '0;
         beats_left = '0;
         o_arready  = 1'b0;
         o_rvalid   = 1'b0;
         o_rdata    = '0;
         o_rlast    = 1'b0;
      end

   // Transfers happen on the rising edge
   always @(posedge i_clk)
      begin
         ar_hs     <= i_arvalid & o_arready;
         r_hs      <= o_rvalid & i_rready;
         ar_addr_s <= i_araddr;
         ar_len_s  <= i_arlen;
         ar_size_s <= i_arsize;
      end

   always @(negedge i_clk)
      begin
         if (i_rst)
            begin
               busy      = 1'b0;
               o_arready = 1'b0;
               o_rvalid  = 1'b0;
               o_rlast   = 1'b0;
               o_rdata   = '0;
            end
         else
            begin
               if (ar_hs)
                  begin
                     busy       = 1'b1;
                     beat_addr  = ar_addr_s;
                     beats_left = ar_len_s;
                  end
               if (r_hs)
                  begin
                     if (o_rlast)
                        busy = 1'b0;
                     else
                        begin
                           beat_addr  = beat_addr + (`ICACHE_AW'(1) << ar_size_s); // INCR
                           beats_left = beats_left - 1'b1;
                        end
                     o_rvalid = 1'b0;
                  end
               o_arready = ~busy & (~i_gaps | (($random(seed) & 3) != 0));
               // Valid stays up until the beat is taken
               if (busy & ~o_rvalid)
                  o_rvalid = ~i_gaps | (($random(seed) & 3) != 0);
               o_rdata = {beat_addr, ~beat_addr};
               o_rlast = busy & (beats_left == 0);
            end
      end

endmodule

// ==== design/icache_top.sv ====
// Two-way instruction cache top level with fetch, invalidate and AXI read ports
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_top (
   input  logic                                  i_clk,
   input  logic                                  i_rst,
   input  logic                                  i_ce,
   input  logic [`ICACHE_AW-1:0]                 i_addr,
   output logic                                  o_stall,
   output logic                                  o_valid,
   output logic [(8 << `ICACHE_P_WIN_BYTES)-1:0] o_insn,
   input  logic                                  i_inv_we,
   input  logic [`ICACHE_AW-1:0]                 i_inv_addr,
   output logic                                  o_arvalid,
   input  logic                                  i_arready,
   output logic [`ICACHE_AW-1:0]                 o_araddr,
   output logic [7:0]                            o_arlen,
   output logic [2:0]                            o_arsize,
   input  logic                                  i_rvalid,
   output logic                                  o_rready,
   input  logic [(8 << `ICACHE_P_WIN_BYTES)-1:0] i_rdata,
   input  logic                                  i_rlast
);
   import icache_pkg::*;

   logic [idx_w-1:0]  boot_idx;
   logic              boot_last;
   logic [beat_w-1:0] beat_idx;
   logic [ways_n-1:0] victim;
   logic              s1_valid;
   logic              hit;
   paddr_u            miss_addr;
   logic              beat_fire;
   logic              r_last;

   icache_ctrl_if u_ctrl_if ();

   icache_ctrl_fsm u_fsm (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ce        (i_ce),
      .i_inv_we    (i_inv_we),
      .i_s1_valid  (s1_valid),
      .i_hit       (hit),
      .i_boot_last (boot_last),
      .i_r_last    (r_last),
      .o_stall     (o_stall),
      .ctrl        (u_ctrl_if)
   );

   icache_counters u_counters (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_state     (u_ctrl_if.state),
      .i_beat_fire (beat_fire),
      .o_boot_idx  (boot_idx),
      .o_boot_last (boot_last),
      .o_beat_idx  (beat_idx),
      .o_victim    (victim)
   );

   icache_ways u_ways (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ce        (i_ce),
      .i_addr      (i_addr),
      .i_inv_addr  (i_inv_addr),
      .i_boot_idx  (boot_idx),
      .i_beat_idx  (beat_idx),
      .i_victim    (victim),
      .i_rdata     (i_rdata),
      .i_beat_fire (beat_fire),
      .ctrl        (u_ctrl_if),
      .o_s1_valid  (s1_valid),
      .o_hit       (hit),
      .o_miss_addr (miss_addr),
      .o_valid     (o_valid),
      .o_insn      (o_insn)
   );

   icache_axi_rd u_axi_rd (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_miss_addr (miss_addr),
      .ctrl        (u_ctrl_if),
      .i_arready   (i_arready),
      .i_rvalid    (i_rvalid),
      .i_rlast     (i_rlast),
      .o_arvalid   (o_arvalid),
      .o_araddr    (o_araddr),
      .o_arlen     (o_arlen),
      .o_arsize    (o_arsize),
      .o_rready    (o_rready),
      .o_beat_fire (beat_fire),
      .o_r_last    (r_last)
   );

endmodule

// ==== design/icache_axi_rd.sv ====
// AXI read master for line refills, AR register and R beat acceptance
`timescale 1ns/1ps

`include "icache_cfg.svh"

module icache_axi_rd (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  icache_pkg::paddr_u    i_miss_addr,
   icache_ctrl_if.axi            ctrl,
   input  logic                  i_arready,
   input  logic                  i_rvalid,
   input  logic                  i_rlast,
   output logic                  o_arvalid,
   output logic [`ICACHE_AW-1:0] o_araddr,
   output logic [7:0]            o_arlen,
   output logic [2:0]            o_arsize,
   output logic                  o_rready,
   output logic                  o_beat_fire,
   output logic                  o_r_last
);
   import icache_pkg::*;

   paddr_u line_addr;
   logic   ar_fire;

   // Burst starts at the first window of the line
   always_comb
      begin
         line_addr        = i_miss_addr;
         line_addr.f.beat = '0;
         line_addr.f.offs = '0;
      end

   assign ar_fire = o_arvalid & i_arready;

   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            o_arvalid <= 1'b0;
         else if (ctrl.ar_start)
            o_arvalid <= 1'b1;
         else if (ar_fire)
            o_arvalid <= 1'b0; // Accepted
      end

   // Address is stable while AR waits
   always_ff @(posedge i_clk)
      begin
         if (ctrl.ar_start)
            o_araddr <= line_addr.raw;
      end

   // INCR burst of full-width beats
   assign o_arlen  = 8'((1 << beat_w) - 1);
   assign o_arsize = 3'(`ICACHE_P_WIN_BYTES);

   assign o_rready    = (ctrl.state == S_REFILL);
   assign o_beat_fire = i_rvalid & o_rready;
   assign o_r_last    = o_beat_fire & i_rlast; // Ends the refill

endmodule

// ==== design/icache_ways.sv ====
// Tag and payload arrays per way, hit compare and fetch window output
`timescale 1ns/1ps

module icache_ways (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_ce,
   input  icache_pkg::paddr_u            i_addr,
   input  icache_pkg::paddr_u            i_inv_addr,
   input  logic [icache_pkg::idx_w-1:0]  i_boot_idx,
   input  logic [icache_pkg::beat_w-1:0] i_beat_idx,
   input  logic [icache_pkg::ways_n-1:0] i_victim,
   input  icache_pkg::win_t              i_rdata,
   input  logic                          i_beat_fire,
   icache_ctrl_if.ways                   ctrl,
   output logic                          o_s1_valid,
   output logic                          o_hit,
   output icache_pkg::paddr_u            o_miss_addr,
   output logic                          o_valid,
   output icache_pkg::win_t              o_insn
);
   import icache_pkg::*;

   localparam int SETS      = 1 << idx_w;
   localparam int PAY_DEPTH = 1 << (idx_w + beat_w);

   paddr_u              s1_addr;
   paddr_u              s2_addr;
   paddr_u              inv_addr_q;
   logic [ways_n-1:0]   victim_q;
   logic [idx_w-1:0]    arr_idx;
   logic [beat_w-1:0]   arr_beat;
   tagv_t               tag_wdata;
   tagv_t               tag_rd [ways_n];
   win_t                pay_rd [ways_n];
   logic [ways_n-1:0]   hit_vec;
   win_t                hit_win;
   logic                refill_take;

   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            begin
               o_s1_valid <= 1'b0;
               o_valid    <= 1'b0;
            end
         else if (i_ce)
            begin
               o_s1_valid <= 1'b1;
               o_valid    <= o_s1_valid;
            end
      end

   always_ff @(posedge i_clk)
      begin
         if (i_ce)
            begin
               s1_addr    <= i_addr;
               s2_addr    <= s1_addr; // Held through a miss
               inv_addr_q <= i_inv_addr;
            end
         if (ctrl.state == S_REPLACE)
            victim_q <= i_victim; // Refill target
      end

   // Array index by state
   always_comb
      begin
         arr_idx  = i_addr.f.idx;
         arr_beat = i_addr.f.beat;
         case (ctrl.state)
            S_BOOT:       arr_idx = i_boot_idx;
            S_INVALIDATE: arr_idx = inv_addr_q.f.idx;
            S_REPLACE:    arr_idx = s2_addr.f.idx;
            S_REFILL:
               begin
                  arr_idx  = s2_addr.f.idx;
                  arr_beat = i_beat_idx;
               end
            S_RELOAD:
               begin
                  arr_idx  = s1_addr.f.idx;
                  arr_beat = s1_addr.f.beat;
               end
            default: ;
         endcase
      end

   assign tag_wdata = ctrl.tag_wsel ? {s2_addr.f.tag, 1'b1} : '0;

   for (genvar w = 0; w < ways_n; w++)
      begin : g_way
         tagv_t tag_mem [SETS];
         win_t  pay_mem [PAY_DEPTH];
         logic  tag_we_w;
         logic  pay_we_w;

         assign tag_we_w = ctrl.tag_we[w] & (~ctrl.tag_wsel | i_victim[w]);
         assign pay_we_w = ctrl.pay_we & i_beat_fire & victim_q[w];

         always_ff @(posedge i_clk)
            begin
               if (tag_we_w)
                  tag_mem[arr_idx] <= tag_wdata;
               if (pay_we_w)
                  pay_mem[{arr_idx, arr_beat}] <= i_rdata;
               if (ctrl.arr_re)
                  begin
                     tag_rd[w] <= tag_mem[arr_idx];
                     pay_rd[w] <= pay_mem[{arr_idx, arr_beat}];
                  end
            end

         assign hit_vec[w] = tag_rd[w].v & (tag_rd[w].tag == s1_addr.f.tag);
      end

   always_comb
      begin
         hit_win = '0;
         for (int w = 0; w < ways_n; w++)
            if (hit_vec[w])
               hit_win = hit_win | pay_rd[w]; // At most one way matches
      end

   assign o_hit       = |hit_vec;
   assign o_miss_addr = s2_addr;

   // Beat of the missed window goes straight to the output
   assign refill_take = ctrl.pay_we & i_beat_fire & (i_beat_idx == s2_addr.f.beat);

   always_ff @(posedge i_clk)
      begin
         if (i_ce)
            o_insn <= hit_win;
         else if (refill_take)
            o_insn <= i_rdata;
      end

endmodule

// ==== design/icache_counters.sv ====
// Boot set counter, refill beat counter and round-robin victim pointer
`timescale 1ns/1ps

module icache_counters (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  icache_pkg::ic_state_e         i_state,
   input  logic                          i_beat_fire,
   output logic [icache_pkg::idx_w-1:0]  o_boot_idx,
   output logic                          o_boot_last,
   output logic [icache_pkg::beat_w-1:0] o_beat_idx,
   output logic [icache_pkg::ways_n-1:0] o_victim
);
   import icache_pkg::*;

   // One set cleared per cycle
   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            o_boot_idx <= '0;
         else if (i_state == S_BOOT)
            o_boot_idx <= o_boot_idx + 1'b1;
      end

   assign o_boot_last = &o_boot_idx;

   // Wraps to zero after the last beat of a line
   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            o_beat_idx <= '0;
         else if ((i_state == S_REFILL) & i_beat_fire)
            o_beat_idx <= o_beat_idx + 1'b1;
      end

   // One-hot pointer, steps once per replacement
   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            o_victim <= ways_n'(1);
         else if (i_state == S_REPLACE)
            o_victim <= {o_victim[ways_n-2:0], o_victim[ways_n-1]};
      end

endmodule

// ==== design/icache_ctrl_fsm.sv ====
// Main cache FSM with boot, refill and invalidate sequencing
`timescale 1ns/1ps

module icache_ctrl_fsm (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_ce,
   input  logic        i_inv_we,
   input  logic        i_s1_valid,
   input  logic        i_hit,
   input  logic        i_boot_last,
   input  logic        i_r_last,
   output logic        o_stall,
   icache_ctrl_if.ctrl ctrl
);
   import icache_pkg::*;

   ic_state_e state_q;
   ic_state_e state_nxt;
   logic      miss;
   logic      tag_clr;

   assign miss = i_s1_valid & ~i_hit; // Stage 1 item not found

   always_comb
      begin
         state_nxt = state_q;
         case (state_q)
            S_BOOT:
               if (i_boot_last)
                  state_nxt = S_IDLE;

            S_IDLE:
               if (i_ce)
                  begin
                     // Invalidate wins over a pending miss
                     if (i_inv_we)
                        state_nxt = S_INVALIDATE;
                     else if (miss)
                        state_nxt = S_REPLACE;
                  end

            S_REPLACE:
               state_nxt = S_REFILL;

            S_REFILL:
               if (i_r_last)
                  state_nxt = S_RELOAD;

            S_INVALIDATE:
               state_nxt = S_IDLE;

            S_RELOAD:
               state_nxt = S_IDLE;

            default:
               state_nxt = S_BOOT;
         endcase
      end

   always_ff @(posedge i_clk)
      begin
         if (i_rst)
            state_q <= S_BOOT;
         else
            state_q <= state_nxt;
      end

   // Boot and invalidate clear every way of the set
   assign tag_clr = (state_q == S_BOOT) | (state_q == S_INVALIDATE);

   assign ctrl.state    = state_q;
   assign ctrl.arr_re   = ((state_q == S_IDLE) & i_ce) | (state_q == S_RELOAD); // Re-read stage 1
   assign ctrl.tag_we   = {ways_n{tag_clr | (state_q == S_REPLACE)}};
   assign ctrl.tag_wsel = (state_q == S_REPLACE); // Victim way only
   assign ctrl.pay_we   = (state_q == S_REFILL);
   assign ctrl.ar_start = (state_q == S_REPLACE);

   assign o_stall = (state_q != S_IDLE);

endmodule

// ==== design/icache_ctrl_if.sv ====
// Steering signals from the cache FSM to the array and AXI blocks
`timescale 1ns/1ps

interface icache_ctrl_if;
   import icache_pkg::*;

   ic_state_e         state;
   logic              arr_re;     // Tag and payload read strobe
   logic [ways_n-1:0] tag_we;
   logic              tag_wsel;   // New tag with valid, else all zero
   logic              pay_we;     // Refill beats may be written
   logic              ar_start;   // Launch the line request

   modport ctrl (
      output state,
      output arr_re,
      output tag_we,
      output tag_wsel,
      output pay_we,
      output ar_start
   );

   modport ways (
      input state,
      input arr_re,
      input tag_we,
      input tag_wsel,
      input pay_we
   );

   modport axi (input ar_start, input state);

endinterface

// ==== design/icache_pkg.sv ====
// Shared types and derived widths of the instruction cache
package icache_pkg;

   `include "icache_cfg.svh"

   localparam int tag_w  = `ICACHE_AW - `ICACHE_P_SETS - `ICACHE_P_LINE;
   localparam int idx_w  = `ICACHE_P_SETS;
   localparam int beat_w = `ICACHE_P_LINE - `ICACHE_P_WIN_BYTES; // Windows per line, log2
   localparam int ways_n = 1 << `ICACHE_P_WAYS;

   // One fetch window, also one AXI beat
   typedef logic [(8 << `ICACHE_P_WIN_BYTES)-1:0] win_t;

   // Physical address, raw or split into cache fields
   typedef union packed {
      logic [`ICACHE_AW-1:0] raw;
      struct packed {
         logic [tag_w-1:0]               tag;
         logic [idx_w-1:0]               idx;
         logic [beat_w-1:0]              beat;
         logic [`ICACHE_P_WIN_BYTES-1:0] offs;
      } f;
   } paddr_u;

   typedef struct packed {
      logic [tag_w-1:0] tag;
      logic             v;
   } tagv_t;

   typedef enum logic [2:0] {
      S_BOOT       = 3'd0,
      S_IDLE       = 3'd1,
      S_REPLACE    = 3'd2,
      S_REFILL     = 3'd3,
      S_INVALIDATE = 3'd4,
      S_RELOAD     = 3'd5
   } ic_state_e;

endpackage

// ==== include/icache_cfg.svh ====
// Instruction cache geometry and bus width settings
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Physical address width in bits
`define ICACHE_AW 32

// Log2 of line size in bytes, 32-byte lines
`define ICACHE_P_LINE 5

// Log2 of set count, 16 sets
`define ICACHE_P_SETS 4

// Log2 of way count, 2 ways
`define ICACHE_P_WAYS 1

// Log2 of fetch window in bytes
// The AXI data bus has the same width, so a beat fills one window
`define ICACHE_P_WIN_BYTES 3

// AXI id width, seen only by the memory model
`define ICACHE_AXI_IDW 4

`endif
